// ==== flist.f ====
verilog/chiplet_pkg.sv
verilog/bus_protocol_if.sv
verilog/msg_table_if.sv
verilog/tx_cache.sv
verilog/message_table.sv
verilog/tx_fsm.sv
verilog/endpoint.sv
verilog/chiplet_tx_top.sv
bench/tb_chiplet_tx.sv

// ==== Bender.yml ====
package:
  name: chiplet_tx

sources:
  - verilog/chiplet_pkg.sv
  - verilog/bus_protocol_if.sv
  - verilog/msg_table_if.sv
  - verilog/tx_cache.sv
  - verilog/message_table.sv
  - verilog/tx_fsm.sv
  - verilog/endpoint.sv
  - verilog/chiplet_tx_top.sv
  - target: test
    files:
      - bench/tb_chiplet_tx.sv

// ==== bench/tb_chiplet_tx.sv ====
`timescale 1ns/1ps

module tb_chiplet_tx import chiplet_pkg::*; ();

    localparam int NUM_MSGS = 4;
    localparam node_id_t NODE_ID = 8'h2A;
    localparam logic [31:0] SEED = 32'd8;
    localparam int MARGIN = 4;
    localparam int ENTRY_CYCLES = 8;  // one bus access plus claim latency
    localparam int WORD_CYCLES = 6;   // cache write plus a flit under random stall

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_READ_BUSY,  // read that has to stall behind a packet
        OP_BUILD,      // header at addr, random payload behind it
        OP_SEND,
        OP_EXPECT,
        OP_STALL
    } op_t;

    typedef struct packed {
        op_t op;
        bus_addr_t addr;
        word_t data;
        strobe_t strobe;
        word_t exp_rdata;
        logic exp_err;
    } entry_t;

    logic clk;
    logic n_rst;
    logic bus_wen;
    logic bus_ren;
    bus_addr_t bus_addr;
    word_t bus_wdata;
    strobe_t bus_strobe;
    word_t bus_rdata;
    logic bus_error;
    logic bus_request_stall;
    logic link_stall;
    word_t flit;
    logic flit_valid;
    logic flit_last;

    entry_t table_q[$];
    word_t got_flit[$];
    logic got_last[$];
    word_t ref_mem [CACHE_NUM_WORDS];
    cache_addr_t ref_start [NUM_MSGS];
    logic [NUM_MSGS-1:0] ref_pending = '0;
    logic busy = 1'b0;                  // a claimed packet not yet checked
    int claimed_id;
    cache_addr_t claimed_start;
    logic [31:0] data_state = SEED;
    logic [31:0] stall_state = SEED;
    logic stall_random = 1'b0;
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int cycle_limit;

    chiplet_tx_top #(
        .NUM_MSGS(NUM_MSGS),
        .NODE_ID(NODE_ID)
    ) i_dut (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic add_entry(input op_t op, input bus_addr_t addr, input word_t data,
                             input strobe_t strobe, input word_t exp_rdata, input logic exp_err);
        entry_t e;
        e.op = op;
        e.addr = addr;
        e.data = data;
        e.strobe = strobe;
        e.exp_rdata = exp_rdata;
        e.exp_err = exp_err;
        table_q.push_back(e);
    endtask

    task automatic bus_access(input logic write, input bus_addr_t addr, input word_t data,
                              input strobe_t strb, output word_t rdata, output logic err,
                              output int stalls);
        stalls = 0;
        @(posedge clk);
        bus_wen <= write;
        bus_ren <= !write;
        bus_addr <= addr;
        bus_wdata <= data;
        bus_strobe <= strb;
        @(negedge clk);
        while (bus_request_stall) begin
            stalls++;
            @(negedge clk);
        end
        rdata = bus_rdata;
        err = bus_error;
        @(posedge clk);  // write lands on this edge
        bus_wen <= 1'b0;
        bus_ren <= 1'b0;
    endtask

    task automatic model_write(input bus_addr_t addr, input word_t data, input strobe_t strb);
        int w;
        if (addr < NUM_MSGS * 4) begin
            ref_start[addr / 4] = {data[8:2], 2'b00};
        end else if (addr >= TX_CACHE_START_ADDR &&
                     addr < TX_CACHE_START_ADDR + CACHE_NUM_WORDS * 4) begin
            w = (addr - TX_CACHE_START_ADDR) / 4;
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    ref_mem[w][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
    endtask

    // an idle sender takes the lowest pending message right away
    task automatic model_claim();
        if (busy || ref_pending == '0) begin
            return;
        end
        for (int i = 0; i < NUM_MSGS; i++) begin
            if (ref_pending[i]) begin
                claimed_id = i;
                break;
            end
        end
        ref_pending[claimed_id] = 1'b0;
        claimed_start = ref_start[claimed_id];
        busy = 1'b1;
    endtask

    task automatic build_packet(input bus_addr_t offset, input word_t header);
        word_t rdata;
        word_t value;
        logic err;
        int stalls;
        bus_addr_t addr;
        for (int k = 0; k <= header[7:0]; k++) begin
            data_state = lcg_next(data_state);
            value = (k == 0) ? header : data_state;
            addr = TX_CACHE_START_ADDR + 4 * ((offset / 4 + k) % CACHE_NUM_WORDS);
            bus_access(1'b1, addr, value, 4'hF, rdata, err, stalls);
            model_write(addr, value, 4'hF);
        end
    endtask

    task automatic expect_packet();
        word_t header;
        word_t exp_flit;
        int len;
        int w;
        if (!busy) begin
            report_failure("a packet was expected but no message had been triggered");
            return;
        end
        w = claimed_start / 4;
        header = ref_mem[w];
        len = header[7:0];
        while (got_flit.size() < len + 1) begin
            @(negedge clk);
        end
        for (int k = 0; k <= len; k++) begin
            exp_flit = (k == 0) ? {NODE_ID, header[23:0]} : ref_mem[(w + k) % CACHE_NUM_WORDS];
            check_value("flit", got_flit.pop_front(), exp_flit);
            check_value("flit_last", got_last.pop_front(), k == len);
        end
        busy = 1'b0;
        model_claim();
    endtask

    task automatic apply_entry(input entry_t e);
        word_t rdata;
        logic err;
        int stalls;
        case (e.op)
            OP_WRITE: begin
                bus_access(1'b1, e.addr, e.data, e.strobe, rdata, err, stalls);
                check_value("bus_error", err, e.exp_err);
                model_write(e.addr, e.data, e.strobe);
            end
            OP_READ, OP_READ_BUSY: begin
                bus_access(1'b0, e.addr, '0, '0, rdata, err, stalls);
                check_value("bus_rdata", rdata, e.exp_rdata);
                check_value("bus_error", err, e.exp_err);
                if (e.op == OP_READ_BUSY && stalls == 0) begin
                    report_failure("a cache read during a packet was not stalled");
                end
            end
            OP_BUILD: build_packet(e.addr, e.data);
            OP_SEND: begin
                bus_access(1'b1, TX_SEND_ADDR, e.data, 4'hF, rdata, err, stalls);
                check_value("bus_error", err, e.exp_err);
                if (e.data < NUM_MSGS) begin
                    ref_pending[e.data] = 1'b1;
                    model_claim();
                end
            end
            OP_EXPECT: expect_packet();
            OP_STALL: stall_random <= e.data[0];
            default: report_failure("unknown operation in the stimulus table");
        endcase
    endtask

    task automatic load_table();
        add_entry(OP_WRITE, 32'h0000_0000, 32'h0000_0107, 4'hF, '0, 1'b0);
        add_entry(OP_WRITE, 32'h0000_0004, 32'hFFFF_FFFF, 4'hF, '0, 1'b0);
        add_entry(OP_READ, 32'h0000_0000, '0, '0, 32'h0000_0104, 1'b0);
        add_entry(OP_READ, 32'h0000_0004, '0, '0, 32'h0000_01FC, 1'b0);
        add_entry(OP_READ, 32'h0000_1000, '0, '0, 32'hBAD1_BAD1, 1'b0);
        add_entry(OP_WRITE, 32'h0000_2040, 32'h1122_3344, 4'hF, '0, 1'b0);
        add_entry(OP_WRITE, 32'h0000_2040, 32'hAABB_CCDD, 4'h5, '0, 1'b0);
        add_entry(OP_READ, 32'h0000_2040, '0, '0, 32'h11BB_33DD, 1'b0);
        add_entry(OP_BUILD, 32'h0000_0080, 32'hFF00_0008, 4'hF, '0, 1'b0);
        add_entry(OP_WRITE, 32'h0000_0000, 32'h0000_0080, 4'hF, '0, 1'b0);
        add_entry(OP_SEND, '0, 32'd0, 4'hF, '0, 1'b0);
        add_entry(OP_EXPECT, '0, '0, '0, '0, 1'b0);
        add_entry(OP_BUILD, 32'h0000_0100, 32'h1100_AB00, 4'hF, '0, 1'b0);  // zero length
        add_entry(OP_WRITE, 32'h0000_0004, 32'h0000_0100, 4'hF, '0, 1'b0);
        add_entry(OP_SEND, '0, 32'd1, 4'hF, '0, 1'b0);
        add_entry(OP_EXPECT, '0, '0, '0, '0, 1'b0);
        add_entry(OP_STALL, '0, 32'd1, '0, '0, 1'b0);
        add_entry(OP_BUILD, 32'h0000_01F0, 32'h2200_0006, 4'hF, '0, 1'b0);  // wraps to word 0
        add_entry(OP_WRITE, 32'h0000_0008, 32'h0000_01F0, 4'hF, '0, 1'b0);
        add_entry(OP_BUILD, 32'h0000_0180, 32'h3300_0003, 4'hF, '0, 1'b0);
        add_entry(OP_WRITE, 32'h0000_000C, 32'h0000_0180, 4'hF, '0, 1'b0);
        add_entry(OP_SEND, '0, 32'd0, 4'hF, '0, 1'b0);
        add_entry(OP_SEND, '0, 32'd3, 4'hF, '0, 1'b0);
        add_entry(OP_SEND, '0, 32'd2, 4'hF, '0, 1'b0);
        add_entry(OP_SEND, '0, 32'd1, 4'hF, '0, 1'b0);
        add_entry(OP_EXPECT, '0, '0, '0, '0, 1'b0);
        add_entry(OP_EXPECT, '0, '0, '0, '0, 1'b0);
        add_entry(OP_EXPECT, '0, '0, '0, '0, 1'b0);
        add_entry(OP_EXPECT, '0, '0, '0, '0, 1'b0);
        add_entry(OP_SEND, '0, 32'd2, 4'hF, '0, 1'b0);
        add_entry(OP_READ_BUSY, 32'h0000_2040, '0, '0, 32'h11BB_33DD, 1'b0);
        add_entry(OP_EXPECT, '0, '0, '0, '0, 1'b0);
        add_entry(OP_SEND, '0, 32'd4, 4'hF, '0, 1'b1);  // no such slot
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        stall_state = lcg_next(stall_state);
        link_stall <= stall_random && stall_state[16];
    end

    // a flit is taken in every cycle with valid high and no stall
    always @(negedge clk) begin
        if (n_rst && flit_valid && !link_stall) begin
            got_flit.push_back(flit);
            got_last.push_back(flit_last);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            report_failure("timeout, a packet or a bus response never arrived");
            finish_run();
        end
    end

    initial begin
        int packet_words;
        n_rst = 1'b0;
        bus_wen = 1'b0;
        bus_ren = 1'b0;
        bus_addr = '0;
        bus_wdata = '0;
        bus_strobe = '0;
        link_stall = 1'b0;
        load_table();
        packet_words = 0;
        foreach (table_q[i]) begin
            if (table_q[i].op == OP_BUILD) begin
                packet_words += table_q[i].data[7:0] + 1;
            end
        end
        cycle_limit = MARGIN * (ENTRY_CYCLES * table_q.size() + WORD_CYCLES * packet_words);
        repeat (5) @(posedge clk);
        n_rst <= 1'b1;
        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        repeat (32) @(negedge clk);  // give a stray packet time to show up
        if (got_flit.size() != 0) begin
            report_failure($sformatf("%0d flits arrived that no send asked for", got_flit.size()));
        end
        finish_run();
    end

endmodule

// ==== verilog/chiplet_tx_top.sv ====
`timescale 1ns/1ps

module chiplet_tx_top import chiplet_pkg::*; #(
    parameter int NUM_MSGS = 4,
    parameter node_id_t NODE_ID = 8'h2A
) (
    input  logic clk,
    input  logic n_rst,
    input  logic bus_wen,
    input  logic bus_ren,
    input  bus_addr_t bus_addr,
    input  word_t bus_wdata,
    input  strobe_t bus_strobe,
    output word_t bus_rdata,
    output logic bus_error,
    output logic bus_request_stall,
    input  logic link_stall,
    output word_t flit,
    output logic flit_valid,
    output logic flit_last
);

    bus_protocol_if cache_bus ();
    bus_protocol_if fsm_bus ();
    msg_table_if #(.NUM_MSGS(NUM_MSGS)) msg_if ();

    cache_addr_t [NUM_MSGS-1:0] pkt_start_addr;

    endpoint #(
        .NUM_MSGS(NUM_MSGS)
    ) i_endpoint (
        .clk(clk),
        .n_rst(n_rst),
        .bus_wen(bus_wen),
        .bus_ren(bus_ren),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_strobe(bus_strobe),
        .bus_rdata(bus_rdata),
        .bus_error(bus_error),
        .bus_request_stall(bus_request_stall),
        .cache_bus(cache_bus.requester),
        .fsm_bus(fsm_bus.responder),
        .msg_if(msg_if.decoder),
        .pkt_start_addr(pkt_start_addr)
    );

    tx_cache #(
        .NUM_WORDS(CACHE_NUM_WORDS)
    ) i_tx_cache (
        .clk(clk),
        .n_rst(n_rst),
        .bus(cache_bus.responder)
    );

    message_table #(
        .NUM_MSGS(NUM_MSGS)
    ) i_message_table (
        .clk(clk),
        .n_rst(n_rst),
        .msg_if(msg_if.tbl)
    );

    tx_fsm #(
        .NUM_MSGS(NUM_MSGS),
        .NODE_ID(NODE_ID)
    ) i_tx_fsm (
        .clk(clk),
        .n_rst(n_rst),
        .msg_if(msg_if.sender),
        .cache_bus(fsm_bus.requester),
        .pkt_start_addr(pkt_start_addr),
        .link_stall(link_stall),
        .flit(flit),
        .flit_valid(flit_valid),
        .flit_last(flit_last)
    );

endmodule

// ==== verilog/endpoint.sv ====
`timescale 1ns/1ps

module endpoint import chiplet_pkg::*; #(
    parameter int NUM_MSGS = 4
) (
    input  logic clk,
    input  logic n_rst,
    input  logic bus_wen,
    input  logic bus_ren,
    input  bus_addr_t bus_addr,
    input  word_t bus_wdata,
    input  strobe_t bus_strobe,
    output word_t bus_rdata,
    output logic bus_error,
    output logic bus_request_stall,
    bus_protocol_if.requester cache_bus,
    bus_protocol_if.responder fsm_bus,
    msg_table_if.decoder msg_if,
    output cache_addr_t [NUM_MSGS-1:0] pkt_start_addr
);

    localparam int IDX_W = $clog2(NUM_MSGS);
    localparam bus_addr_t REG_END_ADDR = bus_addr_t'(NUM_MSGS * 4);

    logic fsm_req;
    logic host_req;
    logic reg_sel;
    logic send_sel;
    logic cache_sel;
    logic [IDX_W-1:0] reg_idx;

    assign fsm_req = fsm_bus.ren || fsm_bus.wen;
    assign host_req = bus_ren || bus_wen;

    // address decode
    assign reg_sel = (bus_addr < REG_END_ADDR);
    assign send_sel = (bus_addr == TX_SEND_ADDR);
    assign cache_sel = (bus_addr >= TX_CACHE_START_ADDR) && (bus_addr < TX_CACHE_END_ADDR);
    assign reg_idx = bus_addr[2 +: IDX_W];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pkt_start_addr <= '0;
        end else if (bus_wen && reg_sel) begin
            pkt_start_addr[reg_idx] <= {bus_wdata[CACHE_ADDR_W-1:2], 2'b00};  // word aligned
        end
    end

    // host response
    always_comb begin
        bus_rdata = BAD_RDATA;
        bus_error = 1'b0;
        bus_request_stall = 1'b0;
        msg_if.trigger_send = '0;
        if (reg_sel) begin
            bus_rdata = word_t'(pkt_start_addr[reg_idx]);
        end else if (send_sel && bus_wen) begin
            if (bus_wdata < word_t'(NUM_MSGS)) begin
                msg_if.trigger_send[bus_wdata[IDX_W-1:0]] = 1'b1;
            end else begin
                bus_error = 1'b1;  // no such message slot
            end
        end else if (cache_sel && host_req) begin
            if (fsm_req) begin
                bus_request_stall = 1'b1;  // packet in flight owns the cache
            end else begin
                bus_rdata = cache_bus.rdata;
                bus_error = cache_bus.error;
                bus_request_stall = cache_bus.request_stall;
            end
        end
    end

    // cache port mux, state machine first
    always_comb begin
        if (fsm_req) begin
            cache_bus.ren = fsm_bus.ren;
            cache_bus.wen = fsm_bus.wen;
            cache_bus.addr = fsm_bus.addr;
            cache_bus.wdata = fsm_bus.wdata;
            cache_bus.strobe = fsm_bus.strobe;
        end else begin
            cache_bus.ren = bus_ren && cache_sel;
            cache_bus.wen = bus_wen && cache_sel;
            cache_bus.addr = bus_addr - TX_CACHE_START_ADDR;  // offset into window
            cache_bus.wdata = bus_wdata;
            cache_bus.strobe = bus_strobe;
        end
    end

    assign fsm_bus.rdata = cache_bus.rdata;
    assign fsm_bus.error = cache_bus.error;
    assign fsm_bus.request_stall = cache_bus.request_stall;

    a_trigger_onehot: assert property (
        @(posedge clk) disable iff (!n_rst)
        $onehot0(msg_if.trigger_send)
    );

endmodule

// ==== verilog/tx_fsm.sv ====
`timescale 1ns/1ps

module tx_fsm import chiplet_pkg::*; #(
    parameter int NUM_MSGS = 4,
    parameter node_id_t NODE_ID = 8'h2A
) (
    input  logic clk,
    input  logic n_rst,
    msg_table_if.sender msg_if,
    bus_protocol_if.requester cache_bus,
    input  cache_addr_t [NUM_MSGS-1:0] pkt_start_addr,
    input  logic link_stall,
    output word_t flit,
    output logic flit_valid,
    output logic flit_last
);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD
    } state_t;

    state_t state, next_state;
    cache_addr_t rd_addr, next_rd_addr;
    pkt_len_t remain, next_remain;
    logic advance;

    // read-only requester, holds the port for the whole packet
    assign cache_bus.ren = (state != IDLE);
    assign cache_bus.wen = 1'b0;
    assign cache_bus.addr = bus_addr_t'(rd_addr);
    assign cache_bus.wdata = '0;
    assign cache_bus.strobe = '0;

    assign msg_if.claim = (state == IDLE) && (|msg_if.pending);

    assign flit_valid = (state != IDLE) && !cache_bus.request_stall;
    assign advance = flit_valid && !link_stall;

    always_comb begin
        flit = cache_bus.rdata;
        flit_last = 1'b0;
        if (state == HEADER) begin
            flit[31:24] = NODE_ID;  // stamp own node id
            flit_last = (cache_bus.rdata[7:0] == '0);
        end else if (state == PAYLOAD) begin
            flit_last = (remain == pkt_len_t'(1));
        end
    end

    always_comb begin
        next_state = state;
        next_rd_addr = rd_addr;
        next_remain = remain;
        case (state)
            IDLE: begin
                if (msg_if.claim) begin
                    next_rd_addr = pkt_start_addr[msg_if.claim_id];
                    next_state = HEADER;
                end
            end
            HEADER: begin
                if (advance) begin
                    next_remain = pkt_len_t'(cache_bus.rdata[7:0]);
                    next_rd_addr = rd_addr + cache_addr_t'(4);  // wraps inside the cache
                    next_state = flit_last ? IDLE : PAYLOAD;
                end
            end
            PAYLOAD: begin
                if (advance) begin
                    next_remain = remain - pkt_len_t'(1);
                    next_rd_addr = rd_addr + cache_addr_t'(4);
                    if (flit_last) begin
                        next_state = IDLE;
                    end
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= IDLE;
            rd_addr <= '0;
            remain <= '0;
        end else begin
            state <= next_state;
            rd_addr <= next_rd_addr;
            remain <= next_remain;
        end
    end

    a_valid_in_packet: assert property (
        @(posedge clk) disable iff (!n_rst)
        flit_valid |-> state inside {HEADER, PAYLOAD}
    );

    // the host must not reach the cache under a stalled flit
    a_stall_holds: assert property (
        @(posedge clk) disable iff (!n_rst)
        flit_valid && link_stall |=> flit_valid && $stable(flit) && $stable(flit_last)
    );

endmodule

// ==== verilog/message_table.sv ====
`timescale 1ns/1ps

module message_table #(
    parameter int NUM_MSGS = 4
) (
    input logic clk,
    input logic n_rst,
    msg_table_if.tbl msg_if
);

    localparam int IDX_W = $clog2(NUM_MSGS);

    logic [NUM_MSGS-1:0] pending;
    logic [NUM_MSGS-1:0] claim_mask;

    assign msg_if.pending = pending;

    // priority encode, lowest index wins
    always_comb begin
        msg_if.claim_id = '0;
        for (int i = NUM_MSGS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                msg_if.claim_id = IDX_W'(i);
            end
        end
    end

    assign claim_mask = msg_if.claim ? (NUM_MSGS'(1) << msg_if.claim_id) : '0;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~claim_mask) | msg_if.trigger_send;  // retrigger wins
        end
    end

    a_claim_pending: assert property (
        @(posedge clk) disable iff (!n_rst)
        msg_if.claim |-> |pending
    );

endmodule

// ==== verilog/tx_cache.sv ====
`timescale 1ns/1ps

module tx_cache import chiplet_pkg::*; #(
    parameter int NUM_WORDS = 128
) (
    input logic clk,
    input logic n_rst,
    bus_protocol_if.responder bus
);

    localparam int IDX_W = $clog2(NUM_WORDS);

    word_t mem [NUM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = bus.addr[2 +: IDX_W];  // word index from byte offset

    // single port, never busy
    assign bus.rdata = mem[idx];
    assign bus.error = 1'b0;
    assign bus.request_stall = 1'b0;

    always_ff @(posedge clk) begin
        if (bus.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.strobe[b]) begin
                    mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // the endpoint arbiter must never merge a host write with a state machine read
    a_no_rw_overlap: assert property (
        @(posedge clk) disable iff (!n_rst)
        !(bus.ren && bus.wen)
    );

endmodule

// ==== verilog/msg_table_if.sv ====
`timescale 1ns/1ps

interface msg_table_if #(
    parameter int NUM_MSGS = 4
) ();

    localparam int IDX_W = $clog2(NUM_MSGS);

    logic [NUM_MSGS-1:0] trigger_send;  // one-cycle pulse per message
    logic [NUM_MSGS-1:0] pending;
    logic claim;                        // takes claim_id off the table
    logic [IDX_W-1:0] claim_id;         // lowest pending index

    modport decoder (
        output trigger_send
    );

    modport tbl (
        input  trigger_send, claim,
        output pending, claim_id
    );

    modport sender (
        input  pending, claim_id,
        output claim
    );

endinterface

// ==== verilog/bus_protocol_if.sv ====
`timescale 1ns/1ps

interface bus_protocol_if import chiplet_pkg::*; ();

    logic wen;
    logic ren;
    bus_addr_t addr;
    word_t wdata;
    strobe_t strobe;

    word_t rdata;
    logic error;
    logic request_stall;  // hold the request while high

    modport requester (
        output wen, ren, addr, wdata, strobe,
        input  rdata, error, request_stall
    );

    modport responder (
        input  wen, ren, addr, wdata, strobe,
        output rdata, error, request_stall
    );

endinterface

// ==== verilog/chiplet_pkg.sv ====
package chiplet_pkg;

    // transmit cache geometry
    localparam int CACHE_NUM_WORDS = 128;
    localparam int CACHE_ADDR_W = $clog2(CACHE_NUM_WORDS) + 2;  // byte offset bits

    // bus and link payload
    typedef logic [31:0] word_t;
    typedef logic [31:0] bus_addr_t;
    typedef logic [3:0] strobe_t;

    typedef logic [CACHE_ADDR_W-1:0] cache_addr_t;

    // header fields
    typedef logic [7:0] node_id_t;  // header bits 31..24
    typedef logic [7:0] pkt_len_t;  // header bits 7..0, payload words

    // host address map
    localparam bus_addr_t TX_SEND_ADDR = 32'h0000_1004;
    localparam bus_addr_t TX_CACHE_START_ADDR = 32'h0000_2000;
    localparam bus_addr_t TX_CACHE_END_ADDR = TX_CACHE_START_ADDR + CACHE_NUM_WORDS * 4;

    localparam word_t BAD_RDATA = 32'hBAD1_BAD1;  // unmapped reads

endpackage
